//--- list.f
+incdir+rtl
rtl/bus_pkg.sv
rtl/bus_addr_decode.sv
rtl/ram_access.sv
rtl/io_regs.sv
rtl/load_format.sv
rtl/soc_bus.sv
tb/tb_soc_bus.sv

//--- Makefile
# Verilator build and run of the bus fabric testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_soc_bus"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_soc_bus \
		-f list.f -o sim_soc_bus
	./obj_dir/sim_soc_bus | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- tb/tb_soc_bus.sv
`timescale 1ns/1ps
`include "bus_consts.svh"

module tb_soc_bus
    import bus_pkg::*;
();

    localparam int    CLK_PERIOD     = 4;
    localparam int    DRIVE_DLY      = 1;
    localparam int    NUM_OPS        = 400;
    localparam int    WIN_WORDS      = 64;                 // RAM window under test
    localparam int    WIN_BYTES      = WIN_WORDS * 4;
    localparam addr_t WIN_BASE       = `RAM_BASE + 64'h100;
    localparam int    TIMEOUT_CYCLES = (NUM_OPS + WIN_WORDS) * 10 + 200;

    logic     CLOCK_50, KEY0;
    addr_t    bus_address;
    dword_t   bus_write_data, bus_read_data;
    access_t  bus_read_type, bus_write_type;
    logic     bus_read_enable, bus_write_enable, bus_read_done;
    byte_t    key_ascii, uart_data;
    logic     key_strobe, interrupt_ack, uart_write;
    irq_vec_t interrupt_vector;

    // reference model
    byte_t    ram_model [WIN_BYTES];
    byte_t    key_model;
    irq_vec_t irq_model;
    word_t    rng;

    soc_bus dut (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run is stuck", TIMEOUT_CYCLES);
        abort_run();
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_dword(string name, dword_t expected, dword_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_byte(string name, byte_t expected, byte_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_irq(string name, irq_vec_t expected, irq_vec_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic word_t rand_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng ^ (rng >> 15);   // fold high bits into the weak low ones
    endfunction

    function automatic addr_t pick_ram_addr(logic [1:0] size);
        int off;
        off = int'(rand_next() % 32'(WIN_BYTES));
        off = off & ~((1 << size) - 1);   // natural alignment
        return WIN_BASE + addr_t'(off);
    endfunction

    function automatic addr_t pick_unmapped();
        word_t r;
        r = rand_next();
        if (r[0])
            return addr_t'(r[11:3]) << 3;            // below RAM
        return 64'h4000 + (addr_t'(r[15:3]) << 3);   // above the I/O registers
    endfunction

    function automatic access_t pick_load_type();
        access_t t;
        t = access_t'(rand_next() >> 8);
        if (t == 3'b111)
            t = 3'b011;   // no unsigned double load
        return t;
    endfunction

    function automatic logic in_ram(addr_t addr);
        return (addr >= `RAM_BASE) && (addr < `RAM_END);
    endfunction

    // little-endian bytes from the model, extended by load type
    function automatic dword_t expect_load(addr_t addr, access_t rtype);
        dword_t raw;
        int     off;
        raw = '0;
        if (addr == `KEY_ADDR)
            return {56'd0, key_model};
        if (addr < WIN_BASE || addr >= WIN_BASE + addr_t'(WIN_BYTES))
            return '0;   // only unmapped addresses are read outside the window
        off = int'(addr - WIN_BASE);
        for (int i = 0; i < 8; i++) begin
            if (off + i < WIN_BYTES)
                raw[8*i +: 8] = ram_model[off + i];
        end
        case (rtype[1:0])
            2'd0:    return rtype[2] ? {56'd0, raw[7:0]} : {{56{raw[7]}}, raw[7:0]};
            2'd1:    return rtype[2] ? {48'd0, raw[15:0]} : {{48{raw[15]}}, raw[15:0]};
            2'd2:    return rtype[2] ? {32'd0, raw[31:0]} : {{32{raw[31]}}, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    task automatic step();
        @(posedge CLOCK_50);
        #DRIVE_DLY;
    endtask

    task automatic do_store(addr_t addr, dword_t data, access_t wtype);
        logic expect_uart;
        int   off;
        expect_uart      = (addr == `UART_ADDR);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_type   = wtype;
        bus_write_enable = 1'b1;
        step();                                  // store sampled here
        bus_write_enable = 1'b0;
        check_flag("uart_write", expect_uart, uart_write);
        if (expect_uart)
            check_byte("uart_data", data[7:0], uart_data);
        step();
        check_flag("uart_write", 1'b0, uart_write);   // single cycle strobe
        step();
        if (in_ram(addr)) begin
            off = int'(addr - WIN_BASE);
            for (int i = 0; i < (1 << wtype[1:0]); i++)
                ram_model[off + i] = data[8*i +: 8];
        end
    endtask

    task automatic do_load(addr_t addr, access_t rtype);
        dword_t expected;
        int     edges;
        int     want;
        expected        = expect_load(addr, rtype);
        want            = (in_ram(addr) && rtype[1:0] == 2'd3) ? 3 : 2;
        bus_address     = addr;
        bus_read_type   = rtype;
        bus_read_enable = 1'b1;
        step();
        bus_read_enable = 1'b0;
        check_flag("bus_read_done", 1'b0, bus_read_done);
        edges = 0;
        while (!bus_read_done) begin
            if (edges >= 10) begin
                $display("read at %h did not finish within 10 cycles", addr);
                abort_run();
            end
            step();
            edges++;
        end
        if (edges != want) begin
            $display("read at %h type %0d took %0d edges instead of %0d",
                     addr, rtype, edges, want);
            abort_run();
        end
        check_dword("bus_read_data", expected, bus_read_data);
    endtask

    task automatic key_event(byte_t ascii, logic strobe, logic ack);
        irq_vec_t next_irq;
        next_irq = irq_model;
        if (strobe && ascii != 8'd0) begin
            key_model = ascii;
            next_irq  = 4'd1;
        end
        if (ack && irq_model != 4'd0)
            next_irq = '0;   // ack wins over a strobe
        key_strobe    = strobe;
        key_ascii     = ascii;
        interrupt_ack = ack;
        step();
        key_strobe    = 1'b0;
        key_ascii     = '0;
        interrupt_ack = 1'b0;
        irq_model     = next_irq;
        check_irq("interrupt_vector", irq_model, interrupt_vector);
    endtask

    initial begin
        addr_t  a;
        dword_t d;
        word_t  r;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_read_type    = '0;
        bus_write_type   = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        key_ascii        = '0;
        key_strobe       = 1'b0;
        interrupt_ack    = 1'b0;
        key_model        = '0;
        irq_model        = '0;
        rng              = 32'hcdc0;

        repeat (5) @(posedge CLOCK_50);
        #DRIVE_DLY;
        KEY0 = 1'b1;
        step();
        check_flag("bus_read_done", 1'b1, bus_read_done);
        check_flag("uart_write", 1'b0, uart_write);
        check_irq("interrupt_vector", '0, interrupt_vector);
        do_load(`KEY_ADDR, 3'b100);

        // fill the window, pattern from the full address
        for (int w = 0; w < WIN_WORDS; w++) begin
            a = WIN_BASE + addr_t'(4 * w);
            do_store(a, {32'd0, (a[31:0] * 32'h9e3779b1) ^ a[63:32]}, 3'b010);
        end

        for (int n = 0; n < NUM_OPS; n++) begin
            r = rand_next();
            d = {rand_next(), rand_next()};
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
                    do_store(pick_ram_addr(r[5:4]), d, {1'b0, r[5:4]});
                4'd6, 4'd7, 4'd8, 4'd9, 4'd10: begin
                    bus_read_type = pick_load_type();
                    do_load(pick_ram_addr(bus_read_type[1:0]), bus_read_type);
                end
                4'd11: begin                    // sd, ld, then byte and word overlays
                    a = pick_ram_addr(2'd3);
                    do_store(a, d, 3'b011);
                    do_load(a, 3'b011);
                    do_store(a + addr_t'(r[10:8]), {56'd0, r[23:16]}, 3'b000);
                    do_store(a + 64'd4, {32'd0, rand_next()}, 3'b010);
                    do_load(a, 3'b011);
                end
                4'd12: begin
                    key_event((r[5:4] == 2'd0) ? 8'd0 : r[15:8], r[6] | r[7], r[9] & r[10]);
                    do_load(`KEY_ADDR, pick_load_type());
                end
                4'd13: begin
                    if (r[4])
                        a = `UART_ADDR;
                    else
                        a = r[5] ? `KEY_ADDR : pick_unmapped();
                    do_store(a, d, {1'b0, r[7:6]});
                end
                4'd14:   do_load(`KEY_ADDR, pick_load_type());
                default: do_load(pick_unmapped(), pick_load_type());
            endcase
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- rtl/soc_bus.sv
`timescale 1ns/1ps

module soc_bus
    import bus_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     KEY0,              // active low reset
    // bus master side
    input  addr_t    bus_address,
    input  dword_t   bus_write_data,
    input  access_t  bus_read_type,
    input  access_t  bus_write_type,
    input  logic     bus_read_enable,
    input  logic     bus_write_enable,
    output dword_t   bus_read_data,
    output logic     bus_read_done,
    // keyboard, interrupt and uart side
    input  byte_t    key_ascii,
    input  logic     key_strobe,
    output irq_vec_t interrupt_vector,
    input  logic     interrupt_ack,
    output byte_t    uart_data,
    output logic     uart_write
);

    logic      ram_sel, key_sel, uart_sel;
    word_idx_t word_idx;
    byte_off_t byte_off;
    word_t     raw_word_lo, raw_word_hi;
    logic      raw_valid;
    byte_t     key_value;

    bus_addr_decode u_decode (
        .address  (bus_address),
        .ram_sel  (ram_sel),
        .key_sel  (key_sel),
        .uart_sel (uart_sel),
        .word_idx (word_idx),
        .byte_off (byte_off)
    );

    ram_access u_ram (
        .clk          (CLOCK_50),
        .rst_n        (KEY0),
        .read_enable  (bus_read_enable),
        .write_enable (bus_write_enable),
        .ram_sel      (ram_sel),
        .word_idx     (word_idx),
        .byte_off     (byte_off),
        .read_type    (bus_read_type),
        .write_type   (bus_write_type),
        .write_data   (bus_write_data),
        .raw_word_lo  (raw_word_lo),
        .raw_word_hi  (raw_word_hi),
        .raw_valid    (raw_valid)
    );

    io_regs u_io (
        .clk              (CLOCK_50),
        .rst_n            (KEY0),
        .key_strobe       (key_strobe),
        .key_ascii        (key_ascii),
        .interrupt_ack    (interrupt_ack),
        .write_enable     (bus_write_enable),
        .uart_sel         (uart_sel),
        .write_data       (bus_write_data),
        .key_value        (key_value),
        .interrupt_vector (interrupt_vector),
        .uart_write       (uart_write),
        .uart_data        (uart_data)
    );

    load_format u_format (
        .clk         (CLOCK_50),
        .rst_n       (KEY0),
        .read_enable (bus_read_enable),
        .raw_valid   (raw_valid),
        .ram_sel     (ram_sel),
        .key_sel     (key_sel),
        .byte_off    (byte_off),
        .read_type   (bus_read_type),
        .raw_word_lo (raw_word_lo),
        .raw_word_hi (raw_word_hi),
        .key_value   (key_value),
        .read_data   (bus_read_data),
        .read_done   (bus_read_done)
    );

endmodule

//--- rtl/load_format.sv
`timescale 1ns/1ps

module load_format
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      read_enable,
    input  logic      raw_valid,
    input  logic      ram_sel,
    input  logic      key_sel,
    input  byte_off_t byte_off,
    input  access_t   read_type,
    input  word_t     raw_word_lo,
    input  word_t     raw_word_hi,
    input  byte_t     key_value,
    output dword_t    read_data,
    output logic      read_done
);

    word_t  shifted;     // addressed byte moved to lane 0
    dword_t ram_value;
    dword_t result;

    assign shifted = raw_word_lo >> {byte_off, 3'b000};

    always_comb begin
        case (read_type)
            3'b000:  ram_value = {{56{shifted[7]}}, shifted[7:0]};     // lb
            3'b100:  ram_value = {56'd0, shifted[7:0]};                // lbu
            3'b001:  ram_value = {{48{shifted[15]}}, shifted[15:0]};   // lh
            3'b101:  ram_value = {48'd0, shifted[15:0]};               // lhu
            3'b010:  ram_value = {{32{shifted[31]}}, shifted};         // lw
            3'b110:  ram_value = {32'd0, shifted};                     // lwu
            3'b011:  ram_value = {raw_word_hi, raw_word_lo};           // ld
            default: ram_value = '0;
        endcase

        if (ram_sel)
            result = ram_value;
        else if (key_sel)
            result = {56'd0, key_value};
        else
            result = '0;   // unmapped reads as zero
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            read_done <= 1'b1;
        else if (raw_valid)
            read_done <= 1'b1;
        else if (read_enable)
            read_done <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (raw_valid)
            read_data <= result;
    end

endmodule

//--- rtl/io_regs.sv
`timescale 1ns/1ps

module io_regs
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     key_strobe,
    input  byte_t    key_ascii,
    input  logic     interrupt_ack,
    input  logic     write_enable,
    input  logic     uart_sel,
    input  dword_t   write_data,
    output byte_t    key_value,
    output irq_vec_t interrupt_vector,
    output logic     uart_write,
    output byte_t    uart_data
);

    logic key_hit;   // strobe carrying a real character

    assign key_hit = key_strobe && (key_ascii != 8'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_value        <= '0;
            interrupt_vector <= '0;
            uart_write       <= 1'b0;
        end else begin
            if (key_hit) begin
                key_value        <= key_ascii;
                interrupt_vector <= irq_vec_t'(1);
            end
            // ack overrides a strobe in the same cycle
            if (interrupt_vector != '0 && interrupt_ack)
                interrupt_vector <= '0;
            uart_write <= write_enable && uart_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (write_enable && uart_sel)
            uart_data <= write_data[7:0];   // low byte only
    end

    // stores are spaced by the master, so the strobe is a lone pulse
    a_uart_single: assert property (@(posedge clk) disable iff (!rst_n)
        uart_write |=> !uart_write);

endmodule

//--- rtl/ram_access.sv
`timescale 1ns/1ps
`include "bus_consts.svh"

module ram_access
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      read_enable,
    input  logic      write_enable,
    input  logic      ram_sel,
    input  word_idx_t word_idx,
    input  byte_off_t byte_off,
    input  access_t   read_type,
    input  access_t   write_type,
    input  dword_t    write_data,
    output word_t     raw_word_lo,
    output word_t     raw_word_hi,
    output logic      raw_valid
);

    word_t mem [`RAM_WORDS];

    rd_state_t rd_state;
    logic      is_ld;       // 64-bit load from RAM
    logic      sd_start;    // first cycle of sd

    // pending high half of an sd
    logic      sd_pend;
    word_idx_t sd_idx;
    word_t     sd_hi;

    // merged write port
    logic      wr_en;
    word_idx_t wr_idx;
    word_t     wr_word;
    logic [3:0] wr_be;

    assign is_ld    = ram_sel && (read_type[1:0] == 2'd3);
    assign sd_start = write_enable && ram_sel && (write_type[1:0] == 2'd3);

    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = word_idx;
        wr_word = write_data[31:0];
        wr_be   = 4'b0000;
        if (sd_pend) begin
            // second half of sd while the master is quiet
            wr_en   = 1'b1;
            wr_idx  = sd_idx;
            wr_word = sd_hi;
            wr_be   = 4'b1111;
        end else if (write_enable && ram_sel) begin
            wr_en = 1'b1;
            case (write_type[1:0])
                2'd0: begin                              // sb
                    wr_word = {4{write_data[7:0]}};
                    wr_be   = 4'b0001 << byte_off;
                end
                2'd1: begin                              // sh
                    wr_word = {2{write_data[15:0]}};
                    wr_be   = byte_off[1] ? 4'b1100 : 4'b0011;
                end
                default: wr_be = 4'b1111;                // sw, low word of sd
            endcase
        end
    end

    // RAM array, sd payload and read words
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i])
                    mem[wr_idx][8*i +: 8] <= wr_word[8*i +: 8];
            end
        end
        if (sd_start) begin
            sd_idx <= word_idx + 1'b1;
            sd_hi  <= write_data[63:32];
        end
        if (rd_state == rd_word && ram_sel)
            raw_word_lo <= mem[word_idx];
        if (rd_state == rd_high)
            raw_word_hi <= mem[word_idx + 1'b1];   // address held by master
    end

    // one word, or two for ld, then a raw_valid pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state  <= rd_idle;
            raw_valid <= 1'b0;
            sd_pend   <= 1'b0;
        end else begin
            raw_valid <= 1'b0;
            sd_pend   <= sd_start;
            case (rd_state)
                rd_idle: begin
                    if (read_enable)
                        rd_state <= rd_word;
                end
                rd_word: begin
                    if (is_ld) begin
                        rd_state <= rd_high;
                    end else begin
                        rd_state  <= rd_idle;
                        raw_valid <= 1'b1;   // also for non-RAM reads
                    end
                end
                rd_high: begin
                    rd_state  <= rd_idle;
                    raw_valid <= 1'b1;
                end
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // byte lanes only cover naturally placed halves and whole words
    a_half_align: assert property (@(posedge clk) disable iff (!rst_n)
        write_enable && ram_sel && write_type[1:0] == 2'd1 |-> !byte_off[0]);

    a_word_align: assert property (@(posedge clk) disable iff (!rst_n)
        write_enable && ram_sel && write_type[1] |-> byte_off == 2'd0);

    a_read_idle: assert property (@(posedge clk) disable iff (!rst_n)
        read_enable |-> rd_state == rd_idle);

endmodule

//--- rtl/bus_addr_decode.sv
`timescale 1ns/1ps
`include "bus_consts.svh"

module bus_addr_decode
    import bus_pkg::*;
(
    input  addr_t     address,
    output logic      ram_sel,
    output logic      key_sel,
    output logic      uart_sel,
    output word_idx_t word_idx,
    output byte_off_t byte_off
);

    addr_t ram_off;   // offset into the RAM region

    assign ram_off  = address - `RAM_BASE;
    assign word_idx = ram_off[$bits(word_idx_t)+1:2];
    assign byte_off = address[1:0];

    always_comb begin
        ram_sel  = (address >= `RAM_BASE) && (address < `RAM_END);
        key_sel  = (address == `KEY_ADDR);
        uart_sel = (address == `UART_ADDR);
    end

endmodule

//--- rtl/bus_pkg.sv
package bus_pkg;

    typedef logic [63:0] addr_t;      // byte address on the bus
    typedef logic [63:0] dword_t;     // bus data, both directions
    typedef logic [31:0] word_t;      // one RAM word
    typedef logic [7:0]  byte_t;      // ascii code, uart byte

    typedef logic [9:0]  word_idx_t;  // RAM word index
    typedef logic [1:0]  byte_off_t;  // byte within a word

    // bit 2 unsigned, bits 1:0 size (byte, half, word, double)
    typedef logic [2:0]  access_t;

    typedef logic [3:0]  irq_vec_t;

    // read sequencer in ram_access
    typedef enum logic [1:0] {
        rd_idle,
        rd_word,    // low (or only) word
        rd_high     // second word of ld
    } rd_state_t;

endpackage

//--- rtl/bus_consts.svh
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// RAM region, word organised
`define RAM_BASE    64'h0000_0000_0000_1000
`define RAM_WORDS   1024
`define RAM_BYTES   (`RAM_WORDS * 4)
`define RAM_END     (`RAM_BASE + `RAM_BYTES)   // first byte past RAM

// single-address I/O registers
`define KEY_ADDR    64'h0000_0000_0000_2000   // last ASCII key, read only
`define UART_ADDR   64'h0000_0000_0000_2008   // tx strobe, write only

`endif
